// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= bev_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/bev_pkg.sv ====
`default_nettype none

package bev_pkg;

    localparam int ING_W = 12;
    localparam int ING_MAX = 4095;
    localparam int NUM_ING = 4;
    localparam int BOX_W = 8;

    // Cup sizes in ml
    localparam int SIZE_S_ML = 480;
    localparam int SIZE_M_ML = 720;
    localparam int SIZE_L_ML = 960;

    typedef enum logic [1:0] {make_drink, supply, check_date} action_t;

    typedef enum logic [2:0] {
        black_tea,
        milk_tea,
        extra_milk_tea,
        green_tea,
        green_milk_tea,
        pineapple_juice,
        super_pineapple_tea,
        super_pineapple_milk_tea
    } bev_type_t;

    typedef enum logic [1:0] {size_s, size_m, size_l} bev_size_t;

    typedef enum logic [1:0] {no_err, no_exp, no_ing, ing_of} err_t;

    typedef enum logic [3:0] {
        idle,
        get_type,
        get_size,
        get_date,
        get_box,
        get_supply,
        read_box,
        judge,
        write_box
    } ctrl_state_t;

    // Lane 0 black tea, 1 green tea, 2 milk, 3 pineapple juice
    typedef logic [NUM_ING-1:0][ING_W-1:0] ing_vec_t;

    typedef struct packed {
        logic [3:0] month;
        logic [4:0] day;
    } date_t;

    typedef struct packed {
        ing_vec_t ing;
        date_t    date;
    } box_rec_t;

    typedef struct packed {
        logic             valid;
        logic             write;
        logic [BOX_W-1:0] addr;
        box_rec_t         wdata;
    } mem_req_t;

    typedef struct packed {
        logic     valid;
        box_rec_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        action_t          action;
        bev_type_t        bev_type;
        bev_size_t        size;
        date_t            today;
        logic [BOX_W-1:0] box;
        ing_vec_t         supply;
    } order_t;

    // Recipe in quarters of the cup, [drink][lane]
    localparam logic [2:0] RECIPE_Q [8][NUM_ING] = '{
        '{3'd4, 3'd0, 3'd0, 3'd0},
        '{3'd3, 3'd0, 3'd1, 3'd0},
        '{3'd2, 3'd0, 3'd2, 3'd0},
        '{3'd0, 3'd4, 3'd0, 3'd0},
        '{3'd0, 3'd2, 3'd2, 3'd0},
        '{3'd0, 3'd0, 3'd0, 3'd4},
        '{3'd2, 3'd0, 3'd0, 3'd2},
        '{3'd2, 3'd0, 3'd1, 3'd1}
    };

endpackage

`default_nettype wire

// ==== logic/bev_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bev_top import bev_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        sel_action_valid,
    input  wire logic        type_valid,
    input  wire logic        size_valid,
    input  wire logic        date_valid,
    input  wire logic        box_no_valid,
    input  wire logic        box_sup_valid,
    input  wire logic [11:0] in_data,
    output logic             out_valid,
    output logic             complete,
    output err_t             err_msg,
    output mem_req_t         mem_req,
    input  mem_rsp_t         mem_rsp
);

    order_t               order;
    logic                 rd_start;
    logic                 wr_start;
    logic                 rd_done;
    box_rec_t             box_rec;
    box_rec_t             new_rec;
    ing_vec_t             operand;
    ing_vec_t             lane_res;
    logic                 add_mode;
    logic [NUM_ING-1:0]   under;
    logic [NUM_ING-1:0]   over;
    err_t                 judge_err;
    logic                 judge_complete;
    logic                 judge_write;

    order_ctrl i_order_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .sel_action_valid (sel_action_valid),
        .type_valid       (type_valid),
        .size_valid       (size_valid),
        .date_valid       (date_valid),
        .box_no_valid     (box_no_valid),
        .box_sup_valid    (box_sup_valid),
        .in_data          (in_data),
        .rd_done          (rd_done),
        .judge_err        (judge_err),
        .judge_complete   (judge_complete),
        .judge_write      (judge_write),
        .order            (order),
        .rd_start         (rd_start),
        .wr_start         (wr_start),
        .out_valid        (out_valid),
        .err_msg          (err_msg),
        .complete         (complete)
    );

    mem_bridge i_mem_bridge (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_start (rd_start),
        .wr_start (wr_start),
        .box      (order.box),
        .new_rec  (new_rec),
        .mem_rsp  (mem_rsp),
        .mem_req  (mem_req),
        .rd_done  (rd_done),
        .box_rec  (box_rec)
    );

    recipe_decoder i_recipe_decoder (
        .order    (order),
        .operand  (operand),
        .add_mode (add_mode)
    );

    // One lane per ingredient
    for (genvar i = 0; i < NUM_ING; i++)
    begin : g_lane
        ing_lane i_ing_lane (
            .stock    (box_rec.ing[i]),
            .operand  (operand[i]),
            .add_mode (add_mode),
            .result   (lane_res[i]),
            .under    (under[i]),
            .over     (over[i])
        );
    end

    stock_judge i_stock_judge (
        .action   (order.action),
        .today    (order.today),
        .box_rec  (box_rec),
        .result   (lane_res),
        .under    (under),
        .over     (over),
        .err      (judge_err),
        .complete (judge_complete),
        .write    (judge_write),
        .new_rec  (new_rec)
    );

endmodule

`default_nettype wire

// ==== logic/ing_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module ing_lane import bev_pkg::*; (
    input  wire logic [ING_W-1:0] stock,
    input  wire logic [ING_W-1:0] operand,
    input  wire logic             add_mode,
    output logic      [ING_W-1:0] result,
    output logic                  under,
    output logic                  over
);

    logic signed [ING_W:0] diff;
    logic        [ING_W:0] sum;

    assign diff = $signed({1'b0, stock}) - $signed({1'b0, operand});
    assign sum  = {1'b0, stock} + {1'b0, operand};

    assign under = !add_mode && (diff < 0);
    assign over  = add_mode && (sum > ING_MAX);

    // Sum clips at full stock
    always_comb
    begin
        if (!add_mode)
            result = diff[ING_W-1:0];
        else if (over)
            result = ING_W'(ING_MAX);
        else
            result = sum[ING_W-1:0];
    end

endmodule

`default_nettype wire

// ==== logic/mem_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_bridge import bev_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             rd_start,
    input  wire logic             wr_start,
    input  wire logic [BOX_W-1:0] box,
    input  box_rec_t              new_rec,
    input  mem_rsp_t              mem_rsp,
    output mem_req_t              mem_req,
    output logic                  rd_done,
    output box_rec_t              box_rec
);

    logic wr_out;
    logic rd_pend;

    // At most one request is in flight, so the write flag tells them apart
    assign rd_done = mem_rsp.valid && !wr_out;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem_req <= '0;
            wr_out  <= 1'b0;
            rd_pend <= 1'b0;
        end
        else
        begin
            mem_req.valid <= 1'b0;
            if (mem_rsp.valid && wr_out)
                wr_out <= 1'b0;

            if (wr_start)
            begin
                mem_req <= '{valid: 1'b1, write: 1'b1, addr: box, wdata: new_rec};
                wr_out  <= 1'b1;
            end
            else if ((rd_start || rd_pend) && !wr_out)
            begin
                mem_req.valid <= 1'b1;
                mem_req.write <= 1'b0;
                mem_req.addr  <= box;
                rd_pend       <= 1'b0;
            end
            // Read waits behind the previous write-back
            else if (rd_start)
                rd_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_done)
            box_rec <= mem_rsp.rdata;
    end

endmodule

`default_nettype wire

// ==== logic/order_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module order_ctrl import bev_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        sel_action_valid,
    input  wire logic        type_valid,
    input  wire logic        size_valid,
    input  wire logic        date_valid,
    input  wire logic        box_no_valid,
    input  wire logic        box_sup_valid,
    input  wire logic [11:0] in_data,
    input  wire logic        rd_done,
    input  err_t             judge_err,
    input  wire logic        judge_complete,
    input  wire logic        judge_write,
    output order_t           order,
    output logic             rd_start,
    output logic             wr_start,
    output logic             out_valid,
    output err_t             err_msg,
    output logic             complete
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic [1:0]  sup_cnt;

    always_comb
    begin
        next_state = state;
        case (state)
            idle:
            begin
                if (sel_action_valid)
                begin
                    case (action_t'(in_data[1:0]))
                        make_drink:         next_state = get_type;
                        supply, check_date: next_state = get_date;
                        default:            next_state = idle;
                    endcase
                end
            end
            get_type:
                if (type_valid) next_state = get_size;
            get_size:
                if (size_valid) next_state = get_date;
            get_date:
                if (date_valid) next_state = get_box;
            get_box:
            begin
                if (box_no_valid)
                    next_state = (order.action == supply) ? get_supply : read_box;
            end
            // Fourth amount closes the supply order
            get_supply:
                if (box_sup_valid && sup_cnt == 2'd3) next_state = read_box;
            read_box:
                if (rd_done) next_state = judge;
            judge:
                next_state = judge_write ? write_box : idle;
            write_box:
                next_state = idle;
            default:
                next_state = idle;
        endcase
    end

    assign wr_start = (state == write_box);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= idle;
            rd_start <= 1'b0;
            sup_cnt  <= 2'd0;
        end
        else
        begin
            state    <= next_state;
            rd_start <= (next_state == read_box) && (state != read_box);
            if (state == idle)
                sup_cnt <= 2'd0;
            else if (state == get_supply && box_sup_valid)
                sup_cnt <= sup_cnt + 2'd1;
        end
    end

    // Order fields
    always_ff @(posedge clk)
    begin
        if (state == idle && sel_action_valid)
            order.action <= action_t'(in_data[1:0]);
        if (state == get_type && type_valid)
            order.bev_type <= bev_type_t'(in_data[2:0]);
        if (state == get_size && size_valid)
            order.size <= bev_size_t'(in_data[1:0]);
        if (state == get_date && date_valid)
            order.today <= date_t'(in_data[8:0]);
        if (state == get_box && box_no_valid)
            order.box <= in_data[BOX_W-1:0];
        if (state == get_supply && box_sup_valid)
            order.supply[sup_cnt] <= in_data[ING_W-1:0];
    end

    // Result is held for exactly one cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            err_msg   <= no_err;
            complete  <= 1'b0;
        end
        else if (state == judge)
        begin
            out_valid <= 1'b1;
            err_msg   <= judge_err;
            complete  <= judge_complete;
        end
        else
        begin
            out_valid <= 1'b0;
            err_msg   <= no_err;
            complete  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/recipe_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module recipe_decoder import bev_pkg::*; (
    input  order_t   order,
    output ing_vec_t operand,
    output logic     add_mode
);

    logic [ING_W-1:0] quarter;

    always_comb
    begin
        case (order.size)
            size_s:  quarter = ING_W'(SIZE_S_ML / 4);
            size_m:  quarter = ING_W'(SIZE_M_ML / 4);
            size_l:  quarter = ING_W'(SIZE_L_ML / 4);
            default: quarter = '0;
        endcase
    end

    assign add_mode = (order.action == supply);

    always_comb
    begin
        operand = '0;
        case (order.action)
            make_drink:
            begin
                for (int i = 0; i < NUM_ING; i++)
                    operand[i] = quarter * ING_W'(RECIPE_Q[order.bev_type][i]);
            end
            supply:
                operand = order.supply;
            // Date check leaves the stock untouched
            default:
                operand = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/stock_judge.sv ====
`timescale 1ns/1ps
`default_nettype none

module stock_judge import bev_pkg::*; (
    input  action_t                  action,
    input  date_t                    today,
    input  box_rec_t                 box_rec,
    input  ing_vec_t                 result,
    input  wire logic [NUM_ING-1:0]  under,
    input  wire logic [NUM_ING-1:0]  over,
    output err_t                     err,
    output logic                     complete,
    output logic                     write,
    output box_rec_t                 new_rec
);

    logic expired;

    // Box date before today, month first
    assign expired = (box_rec.date.month < today.month) ||
                     (box_rec.date.month == today.month && box_rec.date.day < today.day);

    always_comb
    begin
        err = no_err;
        case (action)
            make_drink:
            begin
                if (expired)
                    err = no_exp;
                else if (|under)
                    err = no_ing;
            end
            supply:
                if (|over) err = ing_of;
            check_date:
                if (expired) err = no_exp;
            default:
                err = no_err;
        endcase
    end

    assign complete = (err == no_err);

    // Supply writes even when a lane saturated
    assign write = (action == supply) || (action == make_drink && err == no_err);

    assign new_rec.ing  = result;
    assign new_rec.date = (action == supply) ? today : box_rec.date;

endmodule

`default_nettype wire

// ==== project.f ====
logic/bev_pkg.sv
logic/ing_lane.sv
logic/recipe_decoder.sv
logic/stock_judge.sv
logic/mem_bridge.sv
logic/order_ctrl.sv
logic/bev_top.sv
test/bev_clkgen.sv
test/bev_checker.sv
test/bev_sva.sv
test/bev_tb.sv

// ==== test/bev_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module bev_checker import bev_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             out_valid,
    input  wire logic             complete,
    input  err_t                  err_msg,
    input  mem_req_t              mem_req,
    input  err_t                  exp_err,
    input  wire logic             exp_complete,
    input  wire logic             exp_write,
    input  box_rec_t              exp_rec,
    input  wire logic [BOX_W-1:0] exp_box,
    input  int                    row_idx,
    output int                    errors,
    output int                    done_rows
);

    logic pend;
    int   bad;

    always @(posedge clk or negedge rst_n)
    begin : check
        int   now_bad;
        logic wr_seen;
        if (!rst_n)
        begin
            pend      <= 1'b0;
            bad       <= 0;
            errors    <= 0;
            done_rows <= 0;
        end
        else
        begin
            now_bad = 0;
            if (out_valid)
            begin
                if (err_msg !== exp_err)
                begin
                    $display("[ERROR] %0t row %0d err_msg %s expected %s", $time, row_idx,
                             err_msg.name(), exp_err.name());
                    now_bad++;
                end
                if (complete !== exp_complete)
                begin
                    $display("[ERROR] %0t row %0d complete %0b expected %0b", $time, row_idx,
                             complete, exp_complete);
                    now_bad++;
                end
                pend <= 1'b1;
                bad  <= now_bad;
            end
            // Write request lands one cycle after the result
            if (pend)
            begin
                wr_seen = mem_req.valid && mem_req.write;
                if (wr_seen !== exp_write)
                begin
                    $display("[ERROR] %0t row %0d write %0b expected %0b", $time, row_idx,
                             wr_seen, exp_write);
                    now_bad++;
                end
                else if (wr_seen && (mem_req.addr !== exp_box || mem_req.wdata !== exp_rec))
                begin
                    $display("[ERROR] %0t row %0d wrote box %0d data %h expected box %0d %h",
                             $time, row_idx, mem_req.addr, mem_req.wdata, exp_box, exp_rec);
                    now_bad++;
                end
                $display("row %0d %s", row_idx, (bad + now_bad == 0) ? "ok" : "bad");
                if (bad + now_bad != 0)
                    errors <= errors + 1;
                done_rows <= done_rows + 1;
                pend      <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/bev_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module bev_clkgen (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 4 cycles
    initial
    begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/bev_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module bev_sva import bev_pkg::*; (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic out_valid,
    input mem_req_t  mem_req,
    input mem_rsp_t  mem_rsp
);

    logic wr_pend;

    // Write outstanding from request until its response
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wr_pend <= 1'b0;
        else if (mem_req.valid && mem_req.write)
            wr_pend <= 1'b1;
        else if (mem_rsp.valid)
            wr_pend <= 1'b0;
    end

    a_out_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else $error("out_valid held longer than one cycle");

    a_req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.valid |=> !mem_req.valid)
        else $error("mem_req.valid held longer than one cycle");

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req.valid && !mem_req.write) |-> !wr_pend)
        else $error("read issued while a write is outstanding");

endmodule

bind bev_top bev_sva i_bev_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
);

`default_nettype wire

// ==== test/bev_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bev_tb import bev_pkg::*; ();

    typedef struct packed {
        action_t          action;
        bev_type_t        bev_type;
        bev_size_t        size;
        logic [BOX_W-1:0] box;
        ing_vec_t         supply;
        err_t             exp_err;
        logic             exp_complete;
        logic             exp_write;
        box_rec_t         exp_rec;
    } order_row_t;

    localparam date_t TODAY = '{month: 4'd6, day: 5'd15};

    // Quarters of the cup per drink, lanes black, green, milk, pineapple
    int recipe_q [8][4] = '{
        '{4, 0, 0, 0}, '{3, 0, 1, 0}, '{2, 0, 2, 0}, '{0, 4, 0, 0},
        '{0, 2, 2, 0}, '{0, 0, 0, 4}, '{2, 0, 0, 2}, '{2, 0, 1, 1}
    };

    logic clk;
    logic rst_n;
    logic sel_action_valid;
    logic type_valid;
    logic size_valid;
    logic date_valid;
    logic box_no_valid;
    logic box_sup_valid;
    logic [11:0] in_data;
    logic        out_valid;
    logic        complete;
    err_t        err_msg;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;

    order_row_t       rows[$];
    box_rec_t         mem[256];
    box_rec_t         shadow[256];
    err_t             exp_err;
    logic             exp_complete;
    logic             exp_write;
    box_rec_t         exp_rec;
    logic [BOX_W-1:0] exp_box;
    int               row_idx;
    int               errors;
    int               done_rows;
    int               cycles;
    int               cycle_limit;

    bev_clkgen i_clkgen (.clk(clk), .rst_n(rst_n));

    bev_top i_bev_top (
        .clk(clk), .rst_n(rst_n),
        .sel_action_valid(sel_action_valid), .type_valid(type_valid),
        .size_valid(size_valid), .date_valid(date_valid),
        .box_no_valid(box_no_valid), .box_sup_valid(box_sup_valid),
        .in_data(in_data), .out_valid(out_valid), .complete(complete),
        .err_msg(err_msg), .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    bev_checker i_checker (
        .clk(clk), .rst_n(rst_n), .out_valid(out_valid), .complete(complete),
        .err_msg(err_msg), .mem_req(mem_req), .exp_err(exp_err),
        .exp_complete(exp_complete), .exp_write(exp_write), .exp_rec(exp_rec),
        .exp_box(exp_box), .row_idx(row_idx), .errors(errors), .done_rows(done_rows)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 16'hB400;
        return n;
    endfunction

    // Dates run July to December, all after today
    function automatic box_rec_t fill_rec(input int addr);
        box_rec_t r;
        for (int i = 0; i < NUM_ING; i++)
            r.ing[i] = 12'(3000 + addr * 4 + i * 7);
        r.date = '{month: 4'(7 + addr % 6), day: 5'(1 + addr % 28)};
        return r;
    endfunction

    task automatic set_box(input int addr, input ing_vec_t ing, input date_t d);
        mem[addr]    = '{ing: ing, date: d};
        shadow[addr] = '{ing: ing, date: d};
    endtask

    // Reference model over the shadow memory
    task automatic add_row(input action_t a, input bev_type_t t, input bev_size_t s,
                           input int box, input ing_vec_t sup);
        order_row_t r;
        box_rec_t   cur;
        int         v;
        int         cup;
        logic       expired;
        logic       short_ing;
        logic       sat;
        cur = shadow[box];
        cup = (s == size_s) ? 480 : (s == size_m) ? 720 : 960;
        expired = cur.date.month < TODAY.month ||
                  (cur.date.month == TODAY.month && cur.date.day < TODAY.day);
        short_ing = 1'b0;
        sat = 1'b0;
        r = '0;
        r.action = a;
        r.bev_type = t;
        r.size = s;
        r.box = 8'(box);
        r.supply = sup;
        r.exp_rec = cur;
        for (int i = 0; i < NUM_ING; i++)
        begin
            if (a == make_drink)
            begin
                v = int'(cur.ing[i]) - cup / 4 * recipe_q[t][i];
                if (v < 0)
                    short_ing = 1'b1;
                r.exp_rec.ing[i] = 12'(v);
            end
            else if (a == supply)
            begin
                v = int'(cur.ing[i]) + int'(sup[i]);
                if (v > 4095)
                begin
                    sat = 1'b1;
                    v = 4095;
                end
                r.exp_rec.ing[i] = 12'(v);
            end
        end
        if (a == supply)
        begin
            r.exp_rec.date = TODAY;
            r.exp_err = sat ? ing_of : no_err;
        end
        else if (expired)
            r.exp_err = no_exp;
        else if (a == make_drink && short_ing)
            r.exp_err = no_ing;
        else
            r.exp_err = no_err;
        r.exp_complete = (r.exp_err == no_err);
        r.exp_write = (a == supply) || (a == make_drink && r.exp_err == no_err);
        if (r.exp_write)
            shadow[box] = r.exp_rec;
        rows.push_back(r);
    endtask

    task automatic pulse(input int which, input logic [11:0] data);
        @(posedge clk);
        sel_action_valid <= (which == 0);
        type_valid       <= (which == 1);
        size_valid       <= (which == 2);
        date_valid       <= (which == 3);
        box_no_valid     <= (which == 4);
        box_sup_valid    <= (which == 5);
        in_data          <= data;
    endtask

    // Memory model with LFSR response delay
    logic [15:0] lfsr_state = 16'd67;
    logic        busy;
    logic [3:0]  wait_cnt;
    box_rec_t    rsp_data;

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem_rsp <= '0;
            busy = 1'b0;
        end
        else
        begin
            mem_rsp.valid <= 1'b0;
            if (busy)
            begin
                if (wait_cnt == 4'd1)
                begin
                    mem_rsp <= '{valid: 1'b1, rdata: rsp_data};
                    busy = 1'b0;
                end
                else
                    wait_cnt = wait_cnt - 4'd1;
            end
            if (mem_req.valid)
            begin
                wait_cnt = 4'd0;
                for (int b = 0; b < 3; b++)
                begin
                    wait_cnt = {wait_cnt[2:0], lfsr_state[0]};
                    lfsr_state = lfsr_step(lfsr_state);
                end
                wait_cnt = wait_cnt + 4'd1;
                if (mem_req.write)
                    mem[mem_req.addr] = mem_req.wdata;
                rsp_data = mem[mem_req.addr];
                busy = 1'b1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("Timeout after %0d cycles waiting for a result", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        sel_action_valid = 1'b0;
        type_valid = 1'b0;
        size_valid = 1'b0;
        date_valid = 1'b0;
        box_no_valid = 1'b0;
        box_sup_valid = 1'b0;
        in_data = '0;
        cycles = 0;
        cycle_limit = 0;
        row_idx = 0;
        exp_err = no_err;
        exp_complete = 1'b0;
        exp_write = 1'b0;
        exp_rec = '0;
        exp_box = '0;
        for (int a = 0; a < 256; a++)
        begin
            mem[a] = fill_rec(a);
            shadow[a] = fill_rec(a);
        end
        // Amounts listed from pineapple down to black tea
        set_box(20, '{12'd2000, 12'd100, 12'd2000, 12'd2000}, '{4'd9, 5'd1});
        set_box(21, '{12'd50, 12'd50, 12'd50, 12'd50}, '{4'd6, 5'd14});
        set_box(22, '{12'd3000, 12'd3000, 12'd3000, 12'd3000}, '{4'd1, 5'd20});
        set_box(23, '{12'd100, 12'd2000, 12'd4000, 12'd50}, '{4'd2, 5'd2});

        // Every drink in every size, one box per drink
        for (int t = 0; t < 8; t++)
            for (int s = 0; s < 3; s++)
                add_row(make_drink, bev_type_t'(t), bev_size_t'(s), t, '0);
        add_row(make_drink, extra_milk_tea, size_l, 20, '0);
        add_row(make_drink, black_tea, size_l, 21, '0);
        add_row(check_date, black_tea, size_s, 22, '0);
        add_row(make_drink, green_tea, size_s, 22, '0);
        add_row(supply, black_tea, size_s, 23, '{12'd10, 12'd300, 12'd200, 12'd4000});
        add_row(make_drink, milk_tea, size_m, 23, '0);
        add_row(make_drink, super_pineapple_milk_tea, size_l, 23, '0);
        add_row(supply, black_tea, size_s, 30, '{12'd1, 12'd2, 12'd3, 12'd4});
        add_row(check_date, black_tea, size_s, 30, '0);
        add_row(check_date, black_tea, size_s, 40, '0);
        cycle_limit = rows.size() * 40;

        wait (rst_n);
        foreach (rows[n])
        begin
            @(posedge clk);
            row_idx      <= n;
            exp_err      <= rows[n].exp_err;
            exp_complete <= rows[n].exp_complete;
            exp_write    <= rows[n].exp_write;
            exp_rec      <= rows[n].exp_rec;
            exp_box      <= rows[n].box;
            pulse(0, 12'(rows[n].action));
            if (rows[n].action == make_drink)
            begin
                pulse(1, 12'(rows[n].bev_type));
                pulse(2, 12'(rows[n].size));
            end
            pulse(3, {3'b0, TODAY});
            pulse(4, 12'(rows[n].box));
            if (rows[n].action == supply)
                for (int i = 0; i < NUM_ING; i++)
                    pulse(5, rows[n].supply[i]);
            pulse(-1, '0);
            while (!out_valid)
                @(posedge clk);
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("Rows %0d, finished %0d, failed %0d", rows.size(), done_rows, errors);
        if (errors == 0 && done_rows == rows.size())
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
